//--- hw/cps_cpu_pkg.sv
// CPU side definitions for the video subsystem: bus access, register map, palette writes

package cps_cpu_pkg;

    // One CPU bus access, byte selects are active low
    typedef struct packed {
        logic        cs;
        logic        rnw;
        logic [4:0]  addr;
        logic [1:0]  dsn;
        logic [15:0] wdata;
    } cpu_bus_t;

    // Word addresses of the register block
    typedef enum logic [4:0] {
        reg_hpos      = 5'd0,
        reg_vpos      = 5'd1,
        reg_vram_base = 5'd2,
        reg_backdrop  = 5'd3,
        reg_ctrl      = 5'd4,
        reg_pal_addr  = 5'd5,
        reg_pal_data  = 5'd6
    } mmr_reg_e;

    // Palette RAM write, data bits 11:0 hold RGB444
    typedef struct packed {
        logic        we;
        logic [7:0]  addr;
        logic [15:0] data;
    } pal_wr_t;

endpackage

//--- hw/cps_video_pkg.sv
// Screen side definitions: video timing, layer configuration, pixel and colour types

package cps_video_pkg;

    // Counters and strobes from the timing generator
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic [8:0] vrender;     // line being fetched
        logic       hb;
        logic       vb;
        logic       hs;
        logic       vs;
        logic       line_start;
    } video_timing_t;

    // Scroll layer setup as held by the register block
    typedef struct packed {
        logic [8:0]  hpos;
        logic [8:0]  vpos;
        logic [15:0] vram_base;  // word address of the 64x64 map
        logic [7:0]  backdrop;
        logic        enable;
    } layer_cfg_t;

    // Colour 0 is transparent
    typedef struct packed {
        logic [3:0] group;
        logic [3:0] color;
    } layer_pxl_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

endpackage

//--- hw/cps_timing.sv
// Video timing generator: pixel and line counters with blanking, sync and line start

module cps_timing #(
    parameter int H_TOTAL  = 512,
    parameter int H_ACTIVE = 384,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    output cps_video_pkg::video_timing_t  vt
);

    logic [8:0] h_nxt;
    logic [8:0] v_nxt;

    // Next counter values, vdump steps on the horizontal wrap
    always_comb begin
        h_nxt = vt.hdump + 9'd1;
        v_nxt = vt.vdump;
        if (vt.hdump == 9'(H_TOTAL - 1)) begin
            h_nxt = 9'd0;
            if (vt.vdump == 9'(V_TOTAL - 1)) begin
                v_nxt = 9'd0;
            end else begin
                v_nxt = vt.vdump + 9'd1;
            end
        end
    end

    // All strobes are decoded from the next count so they line up with it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Counters at zero sit inside the active area
            vt         <= '0;
            vt.vrender <= 9'd1;
        end else if (pxl_cen) begin
            vt.hdump      <= h_nxt;
            vt.vdump      <= v_nxt;
            vt.hb         <= h_nxt >= 9'(H_ACTIVE);
            vt.vb         <= v_nxt >= 9'(V_ACTIVE);
            vt.hs         <= h_nxt >= 9'(H_ACTIVE + 8) && h_nxt <= 9'(H_ACTIVE + 15);
            vt.vs         <= v_nxt == 9'(V_ACTIVE + 2) || v_nxt == 9'(V_ACTIVE + 3);
            vt.line_start <= h_nxt == 9'd0;
            // Fetch runs one line ahead of the display
            if (v_nxt == 9'(V_TOTAL - 1)) begin
                vt.vrender <= 9'd0;
            end else begin
                vt.vrender <= v_nxt + 9'd1;
            end
        end
    end

endmodule

//--- hw/cps_mmr.sv
// CPU register block: layer setup, readback and auto-incrementing palette window

module cps_mmr (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cps_cpu_pkg::cpu_bus_t      cpu,
    output logic [15:0]                mmr_dout,
    output cps_video_pkg::layer_cfg_t  cfg,
    output cps_cpu_pkg::pal_wr_t       pal_wr
);
    import cps_cpu_pkg::*;

    mmr_reg_e    reg_sel;
    logic        wr_en;
    logic [15:0] hpos_r;
    logic [15:0] vpos_r;
    logic [15:0] base_r;
    logic [15:0] back_r;
    logic [15:0] ctrl_r;
    logic [15:0] pal_addr_r;

    // Byte lane merge, dsn[1] selects the upper byte
    function automatic logic [15:0] lane_wr(input logic [15:0] cur, input logic [15:0] din,
                                            input logic [1:0] dsn);
        logic [15:0] res;
        res = cur;
        if (!dsn[1]) res[15:8] = din[15:8];
        if (!dsn[0]) res[7:0]  = din[7:0];
        return res;
    endfunction

    assign reg_sel = mmr_reg_e'(cpu.addr);
    assign wr_en   = cpu.cs && !cpu.rnw;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hpos_r     <= '0;
            vpos_r     <= '0;
            base_r     <= '0;
            back_r     <= '0;
            ctrl_r     <= '0;
            pal_addr_r <= '0;
            pal_wr     <= '0;
        end else begin
            pal_wr.we <= 1'b0;
            if (wr_en) begin
                case (reg_sel)
                    reg_hpos:      hpos_r     <= lane_wr(hpos_r, cpu.wdata, cpu.dsn);
                    reg_vpos:      vpos_r     <= lane_wr(vpos_r, cpu.wdata, cpu.dsn);
                    reg_vram_base: base_r     <= lane_wr(base_r, cpu.wdata, cpu.dsn);
                    reg_backdrop:  back_r     <= lane_wr(back_r, cpu.wdata, cpu.dsn);
                    reg_ctrl:      ctrl_r     <= lane_wr(ctrl_r, cpu.wdata, cpu.dsn);
                    reg_pal_addr:  pal_addr_r <= lane_wr(pal_addr_r, cpu.wdata, cpu.dsn);
                    reg_pal_data: begin
                        // Palette window, address steps after every data write
                        pal_wr.we   <= 1'b1;
                        pal_wr.addr <= pal_addr_r[7:0];
                        pal_wr.data <= cpu.wdata;
                        pal_addr_r  <= pal_addr_r + 16'd1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Readback, the palette data window reads as zero
    always_comb begin
        case (reg_sel)
            reg_hpos:      mmr_dout = hpos_r;
            reg_vpos:      mmr_dout = vpos_r;
            reg_vram_base: mmr_dout = base_r;
            reg_backdrop:  mmr_dout = back_r;
            reg_ctrl:      mmr_dout = ctrl_r;
            reg_pal_addr:  mmr_dout = pal_addr_r;
            default:       mmr_dout = 16'd0;
        endcase
    end

    assign cfg.hpos      = hpos_r[8:0];
    assign cfg.vpos      = vpos_r[8:0];
    assign cfg.vram_base = base_r;
    assign cfg.backdrop  = back_r[7:0];
    assign cfg.enable    = ctrl_r[0];

endmodule

//--- hw/cps_scroll.sv
// Scroll layer: tile map and graphics ROM fetch into a ping-pong line buffer

module cps_scroll #(
    parameter int H_ACTIVE = 384,
    parameter int H_TOTAL  = 512
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  cps_video_pkg::video_timing_t  vt,
    input  cps_video_pkg::layer_cfg_t     cfg,
    output logic [15:0]                   vram_addr,
    output logic                          vram_cs,
    input  logic [15:0]                   vram_data,
    input  logic                          vram_ok,
    output logic [19:0]                   rom_addr,
    output logic                          rom_cs,
    input  logic [31:0]                   rom_data,
    input  logic                          rom_ok,
    output cps_video_pkg::layer_pxl_t     pxl
);
    import cps_video_pkg::*;

    // One extra tile covers the fine horizontal scroll
    localparam int NT = H_ACTIVE / 8 + 1;
    localparam int NW = $clog2(NT);
    localparam int BW = $clog2(H_ACTIVE);
    // Fetch positions never reach the end of the line
    localparam int XW = $clog2(H_TOTAL);

    typedef enum logic [1:0] {idle, map_req, rom_req, write} fetch_st_e;

    fetch_st_e     st;
    layer_cfg_t    cfg_l;
    logic [8:0]    line_v;
    logic [NW-1:0] tile_n;
    logic [2:0]    pix_i;
    logic [3:0]    group_l;
    logic [31:0]   row_data;
    logic          fill_sel;
    logic          show_sel;
    logic [8:0]    map_y;
    logic [5:0]    map_col;
    logic [XW-1:0] raw_x;
    logic [XW-1:0] buf_x;
    logic          in_line;
    layer_pxl_t    wr_pxl;
    layer_pxl_t    line_buf [2][H_ACTIVE];

    // Map row and tile row both come from the scrolled line
    assign map_y     = line_v + cfg_l.vpos;
    assign map_col   = cfg_l.hpos[8:3] + 6'(tile_n);
    assign vram_addr = cfg_l.vram_base + {4'd0, map_y[8:3], map_col};
    assign vram_cs   = st == map_req;
    assign rom_cs    = st == rom_req;

    assign raw_x   = XW'({tile_n, pix_i});
    assign buf_x   = raw_x - XW'(cfg_l.hpos[2:0]);
    assign in_line = raw_x >= XW'(cfg_l.hpos[2:0]) && buf_x < XW'(H_ACTIVE);
    assign wr_pxl  = '{group: group_l, color: row_data[31:28]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st       <= idle;
            cfg_l    <= '0;
            line_v   <= '0;
            tile_n   <= '0;
            pix_i    <= '0;
            fill_sel <= 1'b0;
        end else if (pxl_cen && vt.line_start) begin
            // New line, a fetch still in flight is dropped
            st       <= map_req;
            cfg_l    <= cfg;
            line_v   <= vt.vrender;
            tile_n   <= '0;
            pix_i    <= '0;
            fill_sel <= ~fill_sel;
        end else begin
            case (st)
                map_req: if (vram_ok) st <= rom_req;
                rom_req: if (rom_ok) st <= write;
                write: begin
                    pix_i <= pix_i + 3'd1;
                    if (pix_i == 3'd7) begin
                        tile_n <= tile_n + 1'b1;
                        st     <= (tile_n == NW'(NT - 1)) ? idle : map_req;
                    end
                end
                default: ;
            endcase
        end
    end

    // Before the swap edge fill_sel still points at the buffer just filled
    assign show_sel = vt.line_start ? fill_sel : ~fill_sel;

    always_ff @(posedge clk) begin
        if (st == map_req && vram_ok) begin
            group_l  <= vram_data[15:12];
            rom_addr <= {5'd0, vram_data[11:0], map_y[2:0]};
        end
        // Leftmost pixel sits in the top nibble
        if (st == rom_req && rom_ok) begin
            row_data <= rom_data;
        end else if (st == write) begin
            row_data <= {row_data[27:0], 4'd0};
        end
        if (st == write && in_line) begin
            line_buf[fill_sel][buf_x[BW-1:0]] <= wr_pxl;
        end
        if (pxl_cen) begin
            if (vt.hdump < 9'(H_ACTIVE)) begin
                pxl <= line_buf[show_sel][vt.hdump[BW-1:0]];
            end else begin
                pxl <= '0;
            end
        end
    end

endmodule

//--- hw/cps_colmix.sv
// Colour mixer: palette lookup, backdrop for transparent pixels, RGB output with blanking

module cps_colmix (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  cps_video_pkg::video_timing_t  vt,
    input  cps_video_pkg::layer_cfg_t     cfg,
    input  cps_cpu_pkg::pal_wr_t          pal_wr,
    input  cps_video_pkg::layer_pxl_t     pxl,
    output cps_video_pkg::rgb_t           rgb,
    output logic                          lhbl_dly,
    output logic                          lvbl_dly
);
    import cps_video_pkg::*;

    logic [11:0] pal_ram [256];
    logic [7:0]  pal_idx;
    logic [11:0] pal_col;
    rgb_t        col_rgb;
    logic        hb_d;
    logic        vb_d;

    // CPU side palette port
    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_ram[pal_wr.addr] <= pal_wr.data[11:0];
        end
    end

    always_comb begin
        // Transparent or disabled layer shows the backdrop
        if (!cfg.enable || pxl.color == 4'd0) begin
            pal_idx = cfg.backdrop;
        end else begin
            pal_idx = pxl;
        end
        pal_col       = pal_ram[pal_idx];
        // Nibble repeat spans the full 8-bit range
        col_rgb.red   = {pal_col[11:8], pal_col[11:8]};
        col_rgb.green = {pal_col[7:4], pal_col[7:4]};
        col_rgb.blue  = {pal_col[3:0], pal_col[3:0]};
    end

    // Blanking takes one stage to catch up with the line buffer read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hb_d     <= 1'b1;
            vb_d     <= 1'b1;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            hb_d     <= vt.hb;
            vb_d     <= vt.vb;
            lhbl_dly <= ~hb_d;
            lvbl_dly <= ~vb_d;
            rgb      <= (hb_d || vb_d) ? '0 : col_rgb;
        end
    end

endmodule

//--- hw/cps_video.sv
// Video subsystem top: timing, CPU registers, scroll layer and colour mixer

module cps_video #(
    parameter int H_TOTAL  = 512,
    parameter int H_ACTIVE = 384,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pxl_cen,
    input  cps_cpu_pkg::cpu_bus_t   cpu,
    output logic [15:0]             mmr_dout,
    output logic [15:0]             vram_addr,
    output logic                    vram_cs,
    input  logic [15:0]             vram_data,
    input  logic                    vram_ok,
    output logic [19:0]             rom_addr,
    output logic                    rom_cs,
    input  logic [31:0]             rom_data,
    input  logic                    rom_ok,
    output logic                    hs,
    output logic                    vs,
    output logic                    lhbl_dly,
    output logic                    lvbl_dly,
    output cps_video_pkg::rgb_t     rgb
);
    import cps_cpu_pkg::*;
    import cps_video_pkg::*;

    video_timing_t vt;
    layer_cfg_t    cfg;
    pal_wr_t       pal_wr;
    layer_pxl_t    scr_pxl;

    // Sync leaves straight from the timing generator
    assign hs = vt.hs;
    assign vs = vt.vs;

    cps_timing #(
        .H_TOTAL  ( H_TOTAL  ),
        .H_ACTIVE ( H_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE )
    ) u_timing (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .vt       ( vt       )
    );

    cps_mmr u_mmr (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cpu      ( cpu      ),
        .mmr_dout ( mmr_dout ),
        .cfg      ( cfg      ),
        .pal_wr   ( pal_wr   )
    );

    cps_scroll #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  )
    ) u_scroll (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .vt        ( vt        ),
        .cfg       ( cfg       ),
        .vram_addr ( vram_addr ),
        .vram_cs   ( vram_cs   ),
        .vram_data ( vram_data ),
        .vram_ok   ( vram_ok   ),
        .rom_addr  ( rom_addr  ),
        .rom_cs    ( rom_cs    ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .pxl       ( scr_pxl   )
    );

    cps_colmix u_colmix (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .vt       ( vt       ),
        .cfg      ( cfg      ),
        .pal_wr   ( pal_wr   ),
        .pxl      ( scr_pxl  ),
        .rgb      ( rgb      ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly )
    );

endmodule

//--- bench/cps_mem_model.sv
// Video RAM and graphics ROM models with closed-form contents and random answer delays

module cps_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] vram_addr,
    input  logic        vram_cs,
    output logic [15:0] vram_data,
    output logic        vram_ok,
    input  logic [19:0] rom_addr,
    input  logic        rom_cs,
    output logic [31:0] rom_data,
    output logic        rom_ok
);
    timeunit 1ns;
    timeprecision 1ps;

    integer     seed = 32'he63f;
    logic [1:0] vram_wait;
    logic [1:0] rom_wait;
    logic       vram_busy;
    logic       rom_busy;

    // Both ports draw from one seed in a fixed order
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vram_ok   <= 1'b0;
            vram_data <= '0;
            vram_wait <= '0;
            vram_busy <= 1'b0;
            rom_ok    <= 1'b0;
            rom_data  <= '0;
            rom_wait  <= '0;
            rom_busy  <= 1'b0;
        end else begin
            // Word at a holds a XOR 16'h5a3c
            if (vram_ok || !vram_cs) begin
                vram_ok   <= 1'b0;
                vram_busy <= 1'b0;
            end else if (!vram_busy) begin
                vram_busy <= 1'b1;
                vram_wait <= 2'($random(seed));
            end else if (vram_wait == 2'd0) begin
                vram_ok   <= 1'b1;
                vram_data <= vram_addr ^ 16'h5a3c;
            end else begin
                vram_wait <= vram_wait - 2'd1;
            end
            // Word at a holds a times the golden ratio constant
            if (rom_ok || !rom_cs) begin
                rom_ok   <= 1'b0;
                rom_busy <= 1'b0;
            end else if (!rom_busy) begin
                rom_busy <= 1'b1;
                rom_wait <= 2'($random(seed));
            end else if (rom_wait == 2'd0) begin
                rom_ok   <= 1'b1;
                rom_data <= 32'(rom_addr) * 32'h9e3779b1;
            end else begin
                rom_wait <= rom_wait - 2'd1;
            end
        end
    end

endmodule

//--- bench/cps_video_tb.sv
// Testbench for the video subsystem: register access, sync timing and captured frames

module cps_video_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cps_cpu_pkg::*;
    import cps_video_pkg::*;

    localparam int H_TOTAL   = 96;
    localparam int H_ACTIVE  = 64;
    localparam int V_TOTAL   = 40;
    localparam int V_ACTIVE  = 32;
    localparam int ROWS      = 6;
    localparam int FRAME_CLK = 2 * H_TOTAL * V_TOTAL;
    localparam int LIMIT     = (ROWS + 1) * 3 * FRAME_CLK + 20000;

    // Layer setup plus an optional palette rewrite
    typedef struct packed {
        layer_cfg_t cfg;
        logic [7:0] pal_base;
        logic [7:0] pal_n;
    } test_row_t;

    logic        clk;
    logic        rst_n;
    logic        pxl_cen = 1'b0;
    cpu_bus_t    cpu;
    logic [15:0] mmr_dout;
    logic [15:0] vram_addr;
    logic        vram_cs;
    logic [15:0] vram_data;
    logic        vram_ok;
    logic [19:0] rom_addr;
    logic        rom_cs;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic        hs;
    logic        vs;
    logic        lhbl_dly;
    logic        lvbl_dly;
    rgb_t        rgb;
    logic [11:0] pal_ref [256];
    int          cycles = 0;

    string name_tab [ROWS] = '{"zero_scroll", "fine_scroll", "scroll_wrap",
                               "layer_off", "vram_base_move", "palette_rewrite"};

    // hpos, vpos, vram_base, backdrop, enable, then palette base and count
    test_row_t test_tab [ROWS] = '{
        '{'{9'd0,   9'd0,   16'h0000, 8'h00, 1'b1}, 8'h00, 8'd0},
        '{'{9'd13,  9'd21,  16'h0000, 8'h21, 1'b1}, 8'h00, 8'd0},
        '{'{9'd491, 9'd500, 16'h0000, 8'h47, 1'b1}, 8'h00, 8'd0},
        '{'{9'd5,   9'd7,   16'h0000, 8'h9c, 1'b0}, 8'h00, 8'd0},
        '{'{9'd0,   9'd0,   16'h3000, 8'h11, 1'b1}, 8'h00, 8'd0},
        '{'{9'd0,   9'd0,   16'h0000, 8'h52, 1'b1}, 8'h50, 8'd16}
    };

    cps_video #(
        .H_TOTAL  ( H_TOTAL  ),
        .H_ACTIVE ( H_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE )
    ) i_cps_video (.*);

    cps_mem_model i_cps_mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) pxl_cen <= ~pxl_cen;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d clock cycles, the frame sequence never finished", cycles);
            $display("Regression failed");
            $fatal(1, "Simulation stopped");
        end
    end

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("Regression failed");
            $fatal(1, "Word mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s expected %b actual %b", name, exp, act);
            $display("Regression failed");
            $fatal(1, "Sync mismatch");
        end
    endtask

    task automatic check_rgb(input string name, input int x, input int y,
                             input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            $display("ERROR %s x=%0d y=%0d expected %h actual %h", name, x, y, exp, act);
            $display("Regression failed");
            $fatal(1, "Pixel mismatch");
        end
    endtask

    task automatic bus_write(input mmr_reg_e r, input logic [15:0] data, input logic [1:0] dsn);
        @(posedge clk);
        cpu <= '{cs: 1'b1, rnw: 1'b0, addr: r, dsn: dsn, wdata: data};
        @(posedge clk);
        cpu <= '0;
    endtask

    task automatic bus_read(input mmr_reg_e r, output logic [15:0] data);
        @(posedge clk);
        cpu <= '{cs: 1'b1, rnw: 1'b1, addr: r, dsn: 2'b00, wdata: 16'h0000};
        @(posedge clk);
        data = mmr_dout;
        cpu <= '0;
    endtask

    task automatic reg_access_test();
        logic [15:0] hi_val;
        logic [15:0] lo_val;
        logic [15:0] merged;
        logic [15:0] rd;
        for (int r = 0; r <= 6; r++) begin
            bus_read(mmr_reg_e'(r), rd);
            check_word("reset_values", 16'h0000, rd);
        end
        for (int r = 0; r <= 5; r++) begin
            hi_val = 16'hc35a + 16'(r) * 16'h1111;
            lo_val = 16'h3ca5 ^ (16'(r) * 16'h0101);
            merged = {hi_val[15:8], lo_val[7:0]};
            bus_write(mmr_reg_e'(r), hi_val, 2'b01);
            bus_write(mmr_reg_e'(r), lo_val, 2'b10);
            // No lane selected, register keeps its value
            bus_write(mmr_reg_e'(r), 16'hffff, 2'b11);
            bus_read(mmr_reg_e'(r), rd);
            check_word("byte_lanes", merged, rd);
        end
        bus_write(reg_pal_data, 16'h0fff, 2'b00);
        bus_read(reg_pal_data, rd);
        check_word("pal_data_read", 16'h0000, rd);
        bus_read(reg_pal_addr, rd);
        check_word("pal_addr_step", merged + 16'd1, rd);
    endtask

    // Entry i holds i times 12'h3a7, inverted on a rewrite
    task automatic load_palette(input logic [7:0] base, input int n, input logic invert);
        logic [11:0] val;
        bus_write(reg_pal_addr, {8'h00, base}, 2'b00);
        for (int i = 0; i < n; i++) begin
            val = 12'((int'(base) + i) * 12'h3a7);
            if (invert) val = ~val;
            bus_write(reg_pal_data, {4'h0, val}, 2'b00);
            pal_ref[8'(int'(base) + i)] = val;
        end
    endtask

    task automatic program_layer(input test_row_t t);
        bus_write(reg_hpos, 16'(t.cfg.hpos), 2'b00);
        bus_write(reg_vpos, 16'(t.cfg.vpos), 2'b00);
        bus_write(reg_vram_base, t.cfg.vram_base, 2'b00);
        bus_write(reg_backdrop, 16'(t.cfg.backdrop), 2'b00);
        bus_write(reg_ctrl, 16'(t.cfg.enable), 2'b00);
        if (t.pal_n != 8'd0) load_palette(t.pal_base, int'(t.pal_n), 1'b1);
    endtask

    // Scrolled tile map, ROM row and palette lookup for one screen pixel
    function automatic rgb_t expected_pixel(input layer_cfg_t c, input int x, input int y);
        logic [8:0]  map_y;
        logic [5:0]  col;
        logic [15:0] map_word;
        logic [19:0] rom_a;
        logic [31:0] rom_word;
        logic [3:0]  color;
        logic [7:0]  idx;
        logic [11:0] p;
        int          raw_x;
        int          i;
        map_y    = 9'(y + int'(c.vpos));
        raw_x    = x + int'(c.hpos % 9'd8);
        col      = 6'(int'(c.hpos / 9'd8) + raw_x / 8);
        map_word = (c.vram_base + 16'(int'(map_y / 9'd8) * 64 + int'(col))) ^ 16'h5a3c;
        rom_a    = 20'(int'(map_word[11:0]) * 8 + int'(map_y % 9'd8));
        rom_word = 32'(rom_a) * 32'h9e3779b1;
        i        = raw_x % 8;
        color    = rom_word[31 - 4 * i -: 4];
        idx      = (!c.enable || color == 4'd0) ? c.backdrop : {map_word[15:12], color};
        p        = pal_ref[idx];
        return '{red: {p[11:8], p[11:8]}, green: {p[7:4], p[7:4]}, blue: {p[3:0], p[3:0]}};
    endfunction

    task automatic next_sample();
        @(posedge clk);
        while (!pxl_cen) @(posedge clk);
    endtask

    task automatic wait_vblank();
        next_sample();
        while (lvbl_dly) next_sample();
    endtask

    // Returns on the first visible pixel of the next frame
    task automatic wait_frame_start();
        wait_vblank();
        while (!lvbl_dly) next_sample();
    endtask

    task automatic capture_frame(input int row);
        layer_cfg_t c;
        string      name;
        int         x;
        int         y;
        int         h;
        int         v;
        int         vis;
        c    = test_tab[row].cfg;
        name = name_tab[row];
        x    = 0;
        y    = 0;
        vis  = 0;
        wait_frame_start();
        for (int k = 0; k < H_TOTAL * V_TOTAL; k++) begin
            if (k > 0) next_sample();
            // Sync leaves the counters two pixels ahead of rgb
            h = (k + 2) % H_TOTAL;
            v = ((k + 2) / H_TOTAL) % V_TOTAL;
            check_bit({name, " hs"}, h >= H_ACTIVE + 8 && h <= H_ACTIVE + 15, hs);
            check_bit({name, " vs"}, v == V_ACTIVE + 2 || v == V_ACTIVE + 3, vs);
            if (lhbl_dly && lvbl_dly) begin
                check_rgb(name, x, y, expected_pixel(c, x, y), rgb);
                vis++;
                x++;
                if (x == H_ACTIVE) begin
                    x = 0;
                    y++;
                end
            end else begin
                // Blanked pixels are black
                check_rgb({name, " blanking"}, x, y, '0, rgb);
            end
        end
        check_word({name, " visible"}, 16'(H_ACTIVE * V_ACTIVE), 16'(vis));
    endtask

    initial begin
        rst_n = 1'b0;
        cpu   = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        reg_access_test();
        load_palette(8'h00, 256, 1'b0);
        for (int row = 0; row < ROWS; row++) begin
            wait_vblank();
            program_layer(test_tab[row]);
            // Frame right after the writes may still mix old and new setup
            wait_frame_start();
            capture_frame(row);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

//--- cps_video.f
hw/cps_cpu_pkg.sv
hw/cps_video_pkg.sv
hw/cps_timing.sv
hw/cps_mmr.sv
hw/cps_scroll.sv
hw/cps_colmix.sv
hw/cps_video.sv
bench/cps_mem_model.sv
bench/cps_video_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := cps_video_tb
FILELIST   := cps_video.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
